// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := fc_crc_rx_tb
FILELIST  := compile.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))
FAIL_MSG  := Checks failed
PASS_MSG  := All checks passed

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation FAILED"; \
		exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== compile.f ====
rtl/crc32_pkg.sv
rtl/fc_frame_pkg.sv
rtl/fc_crc_data_stage.sv
rtl/fc_crc_state_stage.sv
rtl/fc_crc_rx.sv
sim/tb_clock_gen.sv
sim/fc_crc_rx_asserts.sv
sim/fc_crc_rx_tb.sv

// ==== rtl/crc32_pkg.sv ====
`default_nettype none

package crc32_pkg;

        //////////////////////////////////////////////////////////////////////
        // CRC constants and types
        //////////////////////////////////////////////////////////////////////

        // Fibre Channel CRC-32
        // x^32+x^26+x^23+x^22+x^16+x^12+x^11+x^10+x^8+x^7+x^5+x^4+x^2+x+1
        localparam int               CRC_W      = 32;
        localparam logic [CRC_W-1:0] CRC_POLY   = 32'h04C11DB7;

        // Widest data vector fed in one call, MSB enters first
        localparam int               CRC_DATA_W = 64;

        typedef logic [CRC_W-1:0] crc_t;

        //////////////////////////////////////////////////////////////////////
        // Update functions
        //////////////////////////////////////////////////////////////////////

        // One serial step, MSB-first shift register
        function automatic crc_t crc_step(input crc_t c, input logic d);
                logic fb;
                crc_t nxt;
                fb  = c[CRC_W-1] ^ d;
                nxt = {c[CRC_W-2:0], 1'b0};
                if (fb)
                        nxt = nxt ^ CRC_POLY;
                return nxt;
        endfunction

        // Data contribution with the state held at zero.
        // Only the top nbits of d are fed, starting at the MSB
        function automatic crc_t crc_data_terms(input logic [CRC_DATA_W-1:0] d,
                                                input int nbits);
                crc_t c;
                c = '0;
                for (int i = 0; i < CRC_DATA_W; i++)
                begin
                        if (i < nbits)
                                c = crc_step(c, d[CRC_DATA_W-1-i]);
                end
                return c;
        endfunction

        // State contribution after nbits zero data bits
        function automatic crc_t crc_state_terms(input crc_t c, input int nbits);
                crc_t s;
                s = c;
                for (int i = 0; i < CRC_DATA_W; i++)
                begin
                        if (i < nbits)
                                s = crc_step(s, 1'b0);
                end
                return s;
        endfunction

        // Both matrices are linear, so a full update is
        // crc_data_terms(d, n) ^ crc_state_terms(c, n)

endpackage

`default_nettype wire

// ==== rtl/fc_crc_data_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fc_crc_data_stage
        import crc32_pkg::*;
        import fc_frame_pkg::*;
(
        input  wire        clk,
        input  wire        rst_n,
        input  wire beat_t data,
        input  wire        valid,
        input  wire        sop,
        input  wire        eop,
        input  wire        half,
        output crc_t       hi_terms,
        output crc_t       lo_terms,
        output logic       s1_valid,
        output logic       s1_sop,
        output logic       s1_eop,
        output beat_mode_e s1_mode
);

        localparam int HALF_W = WORD_W / 2;

        beat_t mapped;
        word_t up_word;
        crc_t  hi_next;
        crc_t  lo_next;

        //////////////////////////////////////////////////////////////////////
        // Input mapping
        //////////////////////////////////////////////////////////////////////

        assign mapped  = fc_map_beat(data, sop);
        assign up_word = mapped[BEAT_W-1 -: WORD_W];

        //////////////////////////////////////////////////////////////////////
        // Data-only partial terms
        //////////////////////////////////////////////////////////////////////

        // The two halves are folded independently and XORed in stage 2
        always_comb
        begin
                if (half)
                begin
                        // 32-bit matrix, upper word split in 16-bit halves
                        hi_next = crc_data_terms({up_word[WORD_W-1:HALF_W],
                                                  {(BEAT_W-HALF_W){1'b0}}}, WORD_W);
                        lo_next = crc_data_terms({{HALF_W{1'b0}},
                                                  up_word[HALF_W-1:0],
                                                  {(BEAT_W-WORD_W){1'b0}}}, WORD_W);
                end
                else
                begin
                        // 64-bit matrix, split in 32-bit words
                        hi_next = crc_data_terms({mapped[BEAT_W-1:WORD_W],
                                                  {WORD_W{1'b0}}}, BEAT_W);
                        lo_next = crc_data_terms({{WORD_W{1'b0}},
                                                  mapped[WORD_W-1:0]}, BEAT_W);
                end
        end

        //////////////////////////////////////////////////////////////////////
        // Stage 1 registers
        //////////////////////////////////////////////////////////////////////

        // Control pipeline, frame marks qualified by valid
        always_ff @(posedge clk or negedge rst_n)
        begin
                if (!rst_n)
                begin
                        s1_valid <= 1'b0;
                        s1_sop   <= 1'b0;
                        s1_eop   <= 1'b0;
                        s1_mode  <= BEAT_FULL;
                end
                else
                begin
                        s1_valid <= valid;
                        s1_sop   <= valid & sop;
                        s1_eop   <= valid & eop;
                        if (valid)
                                s1_mode <= half ? BEAT_HALF : BEAT_FULL;
                end
        end

        // Partial terms, held over idle cycles
        always_ff @(posedge clk)
        begin
                if (valid)
                begin
                        hi_terms <= hi_next;
                        lo_terms <= lo_next;
                end
        end

endmodule

`default_nettype wire

// ==== rtl/fc_crc_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module fc_crc_rx
        import crc32_pkg::*;
        import fc_frame_pkg::*;
(
        input  wire        clk,
        input  wire        rst_n,
        input  wire beat_t data,
        input  wire        valid,
        input  wire        sop,
        input  wire        eop,
        input  wire        half,
        output crc_t       crc,
        output logic       crc_valid
);

        //////////////////////////////////////////////////////////////////////
        // Stage 1 to stage 2
        //////////////////////////////////////////////////////////////////////

        wire crc_t       hi_terms;
        wire crc_t       lo_terms;
        wire             s1_valid;
        wire             s1_sop;
        wire             s1_eop;
        wire beat_mode_e s1_mode;

        // Byte mapping and data-only terms
        fc_crc_data_stage u_data_stage
        (
                .clk      (clk),
                .rst_n    (rst_n),
                .data     (data),
                .valid    (valid),
                .sop      (sop),
                .eop      (eop),
                .half     (half),
                .hi_terms (hi_terms),
                .lo_terms (lo_terms),
                .s1_valid (s1_valid),
                .s1_sop   (s1_sop),
                .s1_eop   (s1_eop),
                .s1_mode  (s1_mode)
        );

        // State fold, running CRC and result at eop
        fc_crc_state_stage u_state_stage
        (
                .clk       (clk),
                .rst_n     (rst_n),
                .hi_terms  (hi_terms),
                .lo_terms  (lo_terms),
                .s1_valid  (s1_valid),
                .s1_sop    (s1_sop),
                .s1_eop    (s1_eop),
                .s1_mode   (s1_mode),
                .crc       (crc),
                .crc_valid (crc_valid)
        );

endmodule

`default_nettype wire

// ==== rtl/fc_crc_state_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fc_crc_state_stage
        import crc32_pkg::*;
        import fc_frame_pkg::*;
(
        input  wire             clk,
        input  wire             rst_n,
        input  wire crc_t       hi_terms,
        input  wire crc_t       lo_terms,
        input  wire             s1_valid,
        input  wire             s1_sop,
        input  wire             s1_eop,
        input  wire beat_mode_e s1_mode,
        output crc_t            crc,
        output logic            crc_valid
);

        crc_t crc_run;
        crc_t seed;
        crc_t state_terms;
        crc_t crc_next;
        int   fold_bits;

        //////////////////////////////////////////////////////////////////////
        // Seed and state matrix
        //////////////////////////////////////////////////////////////////////

        // A new sop drops whatever partial frame is in crc_run
        assign seed = s1_sop ? '0 : crc_run;

        always_comb
        begin
                // Half beats advance the state by one word only
                fold_bits   = (s1_mode == BEAT_HALF) ? WORD_W : BEAT_W;
                state_terms = crc_state_terms(seed, fold_bits);
                crc_next    = state_terms ^ hi_terms ^ lo_terms;
        end

        //////////////////////////////////////////////////////////////////////
        // Running CRC
        //////////////////////////////////////////////////////////////////////

        // Idle cycles leave the running value untouched
        always_ff @(posedge clk or negedge rst_n)
        begin
                if (!rst_n)
                        crc_run <= '0;
                else if (s1_valid)
                        crc_run <= crc_next;
        end

        //////////////////////////////////////////////////////////////////////
        // Frame result
        //////////////////////////////////////////////////////////////////////

        // One-cycle strobe per eop beat
        always_ff @(posedge clk or negedge rst_n)
        begin
                if (!rst_n)
                        crc_valid <= 1'b0;
                else
                        crc_valid <= s1_valid & s1_eop;
        end

        // Final complement, captured together with the strobe
        always_ff @(posedge clk)
        begin
                if (s1_valid && s1_eop)
                        crc <= ~crc_next;
        end

endmodule

`default_nettype wire

// ==== rtl/fc_frame_pkg.sv ====
`default_nettype none

package fc_frame_pkg;

        //////////////////////////////////////////////////////////////////////
        // Beat layout
        //////////////////////////////////////////////////////////////////////

        localparam int BEAT_W = 64;
        localparam int WORD_W = 32;
        localparam int BYTE_W = 8;

        typedef logic [BEAT_W-1:0] beat_t;
        typedef logic [WORD_W-1:0] word_t;

        // Half beats carry data in the upper word only
        typedef enum logic
        {
                BEAT_FULL = 1'b0,
                BEAT_HALF = 1'b1
        } beat_mode_e;

        //////////////////////////////////////////////////////////////////////
        // Receive mapping
        //////////////////////////////////////////////////////////////////////

        // Bits are reversed inside every byte, and the first word of a
        // frame is complemented, which stands in for an all-ones preset
        function automatic beat_t fc_map_beat(input beat_t beat, input logic sop);
                beat_t m;
                word_t first;
                for (int b = 0; b < BEAT_W / BYTE_W; b++)
                begin
                        for (int k = 0; k < BYTE_W; k++)
                                m[b*BYTE_W + k] = beat[b*BYTE_W + BYTE_W - 1 - k];
                end
                first = m[BEAT_W-1 -: WORD_W];
                if (sop)
                        m[BEAT_W-1 -: WORD_W] = ~first;
                return m;
        endfunction

endpackage

`default_nettype wire

// ==== sim/fc_crc_rx_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module fc_crc_rx_asserts
        import crc32_pkg::*;
(
        input wire       clk,
        input wire       rst_n,
        input wire       valid,
        input wire       eop,
        input wire crc_t crc,
        input wire       crc_valid
);

        //////////////////////////////////////////////////////////////////////
        // Result strobe timing
        //////////////////////////////////////////////////////////////////////

        a_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !crc_valid)
                else $error("crc_valid high while in reset");

        // Two edges from an eop beat to the strobe
        a_eop_latency: assert property (@(posedge clk) disable iff (!rst_n)
                (valid && eop) |-> ##2 crc_valid)
                else $error("crc_valid missing two edges after an eop beat");

        a_no_spurious: assert property (@(posedge clk) disable iff (!rst_n)
                crc_valid |-> $past(valid && eop, 2))
                else $error("crc_valid without an eop beat two edges earlier");

        // Back to back strobes need back to back eop beats
        a_no_stretch: assert property (@(posedge clk) disable iff (!rst_n)
                (crc_valid && $past(crc_valid)) |->
                        ($past(valid && eop, 2) && $past(valid && eop, 3)))
                else $error("crc_valid held high without two eop beats");

        a_crc_known: assert property (@(posedge clk) disable iff (!rst_n)
                crc_valid |-> !$isunknown(crc))
                else $error("crc has unknown bits while crc_valid is high");

endmodule

bind fc_crc_rx fc_crc_rx_asserts u_asserts
(
        .clk       (clk),
        .rst_n     (rst_n),
        .valid     (valid),
        .eop       (eop),
        .crc       (crc),
        .crc_valid (crc_valid)
);

`default_nettype wire

// ==== sim/fc_crc_rx_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fc_crc_rx_tb
        import crc32_pkg::*;
        import fc_frame_pkg::*;
();

        localparam int          NUM_FRAMES   = 200;
        localparam int          NUM_DIRECTED = 4;
        localparam int          MAX_BEATS    = 8;
        localparam int          MAX_GAP      = 3;
        localparam int          CLK_NS       = 10;
        localparam logic [31:0] FC_POLY      = 32'h04C11DB7;
        // Every beat may be followed by MAX_GAP idles, plus pipeline drain
        localparam int          TIMEOUT_NS   = ((NUM_FRAMES + NUM_DIRECTED) * MAX_BEATS
                                                * (MAX_GAP + 1) + 3) * CLK_NS + 2000;

        wire         clk;
        wire         rst_n;
        beat_t       data;
        logic        valid;
        logic        sop;
        logic        eop;
        logic        half;
        wire crc_t   crc;
        wire         crc_valid;

        logic [31:0] rng_state = 32'h85a939a3;
        crc_t        model_crc = '0;
        crc_t        exp_q[$];
        int          due_q[$];
        int          cyc       = 0;
        int          n_pushed  = 0;
        int          n_checked = 0;

        tb_clock_gen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(2)) u_clock_gen
        (
                .clk   (clk),
                .rst_n (rst_n)
        );

        fc_crc_rx u_fc_crc_rx
        (
                .clk       (clk),
                .rst_n     (rst_n),
                .data      (data),
                .valid     (valid),
                .sop       (sop),
                .eop       (eop),
                .half      (half),
                .crc       (crc),
                .crc_valid (crc_valid)
        );

        always @(posedge clk)
                cyc <= cyc + 1;

        //////////////////////////////////////////////////////////////////////
        // Random numbers and reference model
        //////////////////////////////////////////////////////////////////////

        function automatic logic [31:0] next_rand();
                rng_state = rng_state * 32'd1664525 + 32'd1013904223;
                return rng_state;
        endfunction

        function automatic int rand_below(input int n);
                logic [31:0] r;
                r = next_rand();
                return int'(r[31:16]) % n;
        endfunction

        // Bit i of each byte moves to bit 7-i, first word inverted
        function automatic beat_t rx_order(input beat_t beat, input logic first);
                beat_t m;
                for (int i = 0; i < 64; i++)
                        m[i] = beat[(i & ~7) | (7 - (i & 7))];
                if (first)
                        m[63:32] = ~m[63:32];
                return m;
        endfunction

        // MSB-first serial shift register, bit 63 enters first
        function automatic crc_t serial_fold(input crc_t c, input beat_t m, input int nbits);
                crc_t s;
                logic fb;
                s = c;
                for (int i = 0; i < nbits; i++)
                begin
                        fb = s[31] ^ m[63 - i];
                        s  = {s[30:0], 1'b0};
                        if (fb)
                                s = s ^ FC_POLY;
                end
                return s;
        endfunction

        //////////////////////////////////////////////////////////////////////
        // Failure handling and checks
        //////////////////////////////////////////////////////////////////////

        task automatic abort_run(input string why);
                $display("%s", why);
                $display("Checks failed");
                $fatal(1);
        endtask

        task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                                   input string what);
                if (got !== exp)
                        abort_run($sformatf("mismatch at %0t: %s, got %08h, expected %08h",
                                            $time, what, got, exp));
        endtask

        //////////////////////////////////////////////////////////////////////
        // Stimulus
        //////////////////////////////////////////////////////////////////////

        task automatic drive_beat(input beat_t d, input logic s, input logic e,
                                  input logic h);
                @(posedge clk);
                #1;
                data  = d;
                valid = 1'b1;
                sop   = s;
                eop   = e;
                half  = h;
                if (s)
                        model_crc = '0;
                model_crc = serial_fold(model_crc, rx_order(d, s), h ? 32 : 64);
                if (e)
                begin
                        exp_q.push_back(~model_crc);
                        due_q.push_back(cyc + 2);
                        n_pushed++;
                end
        endtask

        // Idle beat, frame marks random but not qualified
        task automatic drive_idle();
                logic [31:0] r;
                @(posedge clk);
                #1;
                r     = next_rand();
                data  = {next_rand(), r};
                valid = 1'b0;
                sop   = r[0];
                eop   = r[1];
                half  = r[2];
        endtask

        task automatic send_frame(input int nbeats, input bit close, input bit gaps,
                                  input bit edge_half);
                beat_t d;
                logic  h;
                bit    last;
                for (int b = 0; b < nbeats; b++)
                begin
                        last = (b == nbeats - 1);
                        d    = {next_rand(), next_rand()};
                        h    = (rand_below(4) == 0);
                        if (edge_half && (b == 0 || last))
                                h = 1'b1;
                        drive_beat(d, b == 0, last && close, h);
                        if (gaps)
                                repeat (rand_below(MAX_GAP + 1))
                                        drive_idle();
                end
        endtask

        // Result monitor, sampled on the falling edge
        always @(negedge clk)
        begin : monitor
                crc_t exp_crc;
                int   due_cyc;
                if (rst_n && crc_valid)
                begin
                        if (exp_q.size() == 0)
                                abort_run($sformatf("crc_valid pulsed at %0t with no frame pending",
                                                    $time));
                        else
                        begin
                                exp_crc = exp_q.pop_front();
                                due_cyc = due_q.pop_front();
                                check_equal(crc, exp_crc, "frame crc");
                                check_equal(cyc, due_cyc, "crc_valid cycle");
                                n_checked++;
                        end
                end
        end

        initial
        begin
                #(TIMEOUT_NS);
                abort_run($sformatf("Run timed out after %0d ns", TIMEOUT_NS));
        end

        initial
        begin
                data  = '0;
                valid = 1'b0;
                sop   = 1'b0;
                eop   = 1'b0;
                half  = 1'b0;
                wait (rst_n === 1'b1);

                // Quiet after reset, strobe only from the first eop
                repeat (6)
                        drive_idle();
                drive_beat({next_rand(), next_rand()}, 1'b1, 1'b1, 1'b0);
                repeat (4)
                        drive_idle();

                // Half beats at both ends of a frame
                send_frame(5, 1'b1, 1'b0, 1'b1);

                // Unfinished frame cut short by a new sop
                send_frame(3, 1'b0, 1'b0, 1'b0);
                send_frame(4, 1'b1, 1'b0, 1'b0);
                drive_idle();

                // Random mix, some frames back to back
                for (int f = 0; f < NUM_FRAMES; f++)
                        send_frame(1 + rand_below(MAX_BEATS), rand_below(8) != 0,
                                   rand_below(3) != 0, rand_below(4) == 0);

                // Pipeline drain, two edges from the last eop plus slack
                repeat (4)
                        drive_idle();

                if (n_checked != n_pushed)
                        abort_run($sformatf("Only %0d of %0d frame results were seen",
                                            n_checked, n_pushed));
                else
                begin
                        $display("All checks passed");
                        $finish;
                end
        end

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen
#(
        parameter int PERIOD_NS    = 10,
        parameter int RESET_CYCLES = 2
)
(
        output logic clk,
        output logic rst_n
);

        initial
        begin
                clk = 1'b0;
                forever
                        #(PERIOD_NS / 2.0) clk = ~clk;
        end

        // Reset low for a fixed count of rising edges
        initial
        begin
                rst_n = 1'b0;
                repeat (RESET_CYCLES)
                        @(posedge clk);
                #1;
                rst_n = 1'b1;
        end

endmodule

`default_nettype wire
